/* hdl/icache_tag_ctrl.sv */
`timescale 1ns/1ps
`include "icache_tag_defs.svh"

module icache_tag_ctrl (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         req_vld,
    input  icache_tag_pkg::fetch_req_t   req,
    output logic                         req_rdy,
    input  logic                         stall,
    input  logic                         dataram_rd_rdy,
    output logic [`ICT_WAYS-1:0]         hit_a,
    output logic [`ICT_WAYS-1:0]         hit_b,
    output logic                         miss_a,
    output logic                         miss_b,
    output logic                         bypass_vld,
    output icache_tag_pkg::dataram_rd_t  bypass_a,
    output icache_tag_pkg::dataram_rd_t  bypass_b,
    output logic                         entry_vld,
    output icache_tag_pkg::miss_entry_t  entry
);

    icache_tag_pkg::lookup_t  lookup_a;
    icache_tag_pkg::lookup_t  lookup_b;
    icache_tag_pkg::refill_t  buf_a;
    icache_tag_pkg::refill_t  buf_b;
    icache_tag_pkg::tag_set_t rd_a;
    icache_tag_pkg::tag_set_t rd_b;
    icache_tag_pkg::tag_set_t ram_wdata;
    logic                     buf_a_vld;
    logic                     buf_b_vld;
    logic                     busy;
    logic                     victim_a;
    logic                     victim_b;
    logic                     req_fire;
    logic                     ram_en;
    logic                     ram_wr;
    logic [`ICT_INDEX_W-1:0]  req_index_a;
    logic [`ICT_INDEX_W-1:0]  req_index_b;
    logic [`ICT_INDEX_W-1:0]  ram_addr_a;
    logic [`ICT_INDEX_W-1:0]  ram_addr_b;

    // ============================================================
    // lookup stage
    // ============================================================
    tag_lookup u_lookup (
        .clk            (clk),
        .rst_n          (rst_n),
        .req_vld        (req_vld),
        .req            (req),
        .stall          (stall),
        .dataram_rd_rdy (dataram_rd_rdy),
        .req_rdy        (req_rdy),
        .busy           (busy),
        .buf_a          (buf_a),
        .buf_b          (buf_b),
        .buf_a_vld      (buf_a_vld),
        .buf_b_vld      (buf_b_vld),
        .rd_a           (rd_a),
        .rd_b           (rd_b),
        .victim_a       (victim_a),
        .victim_b       (victim_b),
        .req_index_a    (req_index_a),
        .req_index_b    (req_index_b),
        .req_fire       (req_fire),
        .lookup_a       (lookup_a),
        .lookup_b       (lookup_b),
        .hit_a          (hit_a),
        .hit_b          (hit_b),
        .miss_a         (miss_a),
        .miss_b         (miss_b),
        .bypass_vld     (bypass_vld),
        .bypass_a       (bypass_a),
        .bypass_b       (bypass_b),
        .entry_vld      (entry_vld),
        .entry          (entry)
    );

    // ============================================================
    // refill and replacement
    // ============================================================
    tag_refill_buffer u_refill (
        .clk         (clk),
        .rst_n       (rst_n),
        .lookup_a    (lookup_a),
        .lookup_b    (lookup_b),
        .victim_a    (victim_a),
        .victim_b    (victim_b),
        .req_index_a (req_index_a),
        .req_index_b (req_index_b),
        .req_fire    (req_fire),
        .buf_a       (buf_a),
        .buf_b       (buf_b),
        .buf_a_vld   (buf_a_vld),
        .buf_b_vld   (buf_b_vld),
        .busy        (busy),
        .ram_en      (ram_en),
        .ram_wr      (ram_wr),
        .ram_addr_a  (ram_addr_a),
        .ram_addr_b  (ram_addr_b),
        .ram_wdata   (ram_wdata)
    );

    lru_table u_lru (
        .clk      (clk),
        .rst_n    (rst_n),
        .lookup_a (lookup_a),
        .lookup_b (lookup_b),
        .victim_a (victim_a),
        .victim_b (victim_b)
    );

    // two copies of the tags, one per lookup
    tag_sram u_tag_ram_a (
        .clk     (clk),
        .en      (ram_en),
        .wr_en   (ram_wr),
        .addr    (ram_addr_a),
        .wr_data (ram_wdata),
        .rd_data (rd_a)
    );

    tag_sram u_tag_ram_b (
        .clk     (clk),
        .en      (ram_en),
        .wr_en   (ram_wr),
        .addr    (ram_addr_b),
        .wr_data (ram_wdata),
        .rd_data (rd_b)
    );

endmodule

/* hdl/icache_tag_defs.svh */
`ifndef ICACHE_TAG_DEFS_SVH
`define ICACHE_TAG_DEFS_SVH

// ============================================================
// address split
// ============================================================

// fetch address width
`define ICT_ADDR_W       16

// 64-byte lines
`define ICT_OFFSET_W     6

// 32 sets
`define ICT_INDEX_W      5

// tag left over from the address
`define ICT_TAG_W        5

// ============================================================
// cache shape
// ============================================================

`define ICT_WAYS         2

// bytes covered by one fetch, used for the line crossing test
`define ICT_FETCH_BYTES  8

// transaction id carried with each request
`define ICT_TXNID_W      4

`endif

/* hdl/icache_tag_pkg.sv */
package icache_tag_pkg;

`include "icache_tag_defs.svh"

    typedef enum logic {
        op_fetch      = 1'b0,
        op_downstream = 1'b1
    } opcode_e;

    typedef struct packed {
        logic [`ICT_TAG_W-1:0]    tag;
        logic [`ICT_INDEX_W-1:0]  index;
        logic [`ICT_OFFSET_W-1:0] offset;
    } fetch_addr_t;

    typedef struct packed {
        fetch_addr_t             addr;
        opcode_e                 opcode;
        logic [`ICT_TXNID_W-1:0] txnid;
    } fetch_req_t;

    typedef struct packed {
        logic                  valid;
        logic [`ICT_TAG_W-1:0] tag;
    } tag_way_t;

    // one RAM word, way 0 in the upper half
    typedef struct packed {
        tag_way_t way0;
        tag_way_t way1;
    } tag_set_t;

    typedef struct packed {
        logic [`ICT_INDEX_W-1:0] index;
        logic                    way;
        logic [`ICT_TXNID_W-1:0] txnid;
    } dataram_rd_t;

    typedef struct packed {
        fetch_req_t req_a;
        fetch_req_t req_b;
        logic       dest_way_a;
        logic       dest_way_b;
    } miss_entry_t;

    typedef struct packed {
        logic [`ICT_INDEX_W-1:0] index;
        tag_set_t                set;
    } refill_t;

    // one lookup with the set it resolved to
    typedef struct packed {
        logic       valid;
        fetch_req_t req;
        tag_set_t   set;
    } lookup_t;

    // per-way hit, way 0 in the msb
    function automatic logic [`ICT_WAYS-1:0] way_hit(tag_set_t ts, logic [`ICT_TAG_W-1:0] tag);
        way_hit = {ts.way0.valid && (ts.way0.tag == tag), ts.way1.valid && (ts.way1.tag == tag)};
    endfunction

endpackage

/* hdl/lru_table.sv */
`timescale 1ns/1ps
`include "icache_tag_defs.svh"

module lru_table (
    input  logic                     clk,
    input  logic                     rst_n,
    input  icache_tag_pkg::lookup_t  lookup_a,
    input  icache_tag_pkg::lookup_t  lookup_b,
    output logic                     victim_a,
    output logic                     victim_b
);

    // one bit per set, 0 picks way 0
    logic [(1 << `ICT_INDEX_W)-1:0] lru;

    // new bit for the set of one lookup
    function automatic logic next_bit(icache_tag_pkg::lookup_t lk, logic cur);
        logic [`ICT_WAYS-1:0] hit;
        hit = icache_tag_pkg::way_hit(lk.set, lk.req.addr.tag);
        if (!lk.set.way0.valid) begin
            return 1'b0;
        end else if (!lk.set.way1.valid) begin
            return 1'b1;
        end else if (hit[1]) begin
            return 1'b1;
        end else if (hit[0]) begin
            return 1'b0;
        end
        // full set and a miss
        return ~cur;
    endfunction

    assign victim_a = lru[lookup_a.req.addr.index];
    assign victim_b = lru[lookup_b.req.addr.index];

    // b goes second so it wins on a shared set
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            lru <= '0;
        end else begin
            if (lookup_a.valid) begin
                lru[lookup_a.req.addr.index] <= next_bit(lookup_a, victim_a);
            end
            if (lookup_b.valid) begin
                lru[lookup_b.req.addr.index] <= next_bit(lookup_b, victim_b);
            end
        end
    end

endmodule

/* hdl/tag_lookup.sv */
`timescale 1ns/1ps
`include "icache_tag_defs.svh"

module tag_lookup (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         req_vld,
    input  icache_tag_pkg::fetch_req_t   req,
    input  logic                         stall,
    input  logic                         dataram_rd_rdy,
    output logic                         req_rdy,
    input  logic                         busy,
    input  icache_tag_pkg::refill_t      buf_a,
    input  icache_tag_pkg::refill_t      buf_b,
    input  logic                         buf_a_vld,
    input  logic                         buf_b_vld,
    input  icache_tag_pkg::tag_set_t     rd_a,
    input  icache_tag_pkg::tag_set_t     rd_b,
    input  logic                         victim_a,
    input  logic                         victim_b,
    output logic [`ICT_INDEX_W-1:0]      req_index_a,
    output logic [`ICT_INDEX_W-1:0]      req_index_b,
    output logic                         req_fire,
    output icache_tag_pkg::lookup_t      lookup_a,
    output icache_tag_pkg::lookup_t      lookup_b,
    output logic [`ICT_WAYS-1:0]         hit_a,
    output logic [`ICT_WAYS-1:0]         hit_b,
    output logic                         miss_a,
    output logic                         miss_b,
    output logic                         bypass_vld,
    output icache_tag_pkg::dataram_rd_t  bypass_a,
    output icache_tag_pkg::dataram_rd_t  bypass_b,
    output logic                         entry_vld,
    output icache_tag_pkg::miss_entry_t  entry
);

    logic                       crossing;
    logic [`ICT_ADDR_W-1:0]     addr_next;
    icache_tag_pkg::fetch_req_t req_line_b;
    logic                       vld;
    icache_tag_pkg::fetch_req_t req_a_q;
    icache_tag_pkg::fetch_req_t req_b_q;
    icache_tag_pkg::tag_set_t   set_a;
    icache_tag_pkg::tag_set_t   set_b;
    logic                       dest_a;
    logic                       dest_b;

    // pending refill data beats the ram word
    function automatic icache_tag_pkg::tag_set_t resolve(
        logic [`ICT_INDEX_W-1:0]  index,
        icache_tag_pkg::tag_set_t ram_set,
        icache_tag_pkg::refill_t  ba,
        logic                     ba_vld,
        icache_tag_pkg::refill_t  bb,
        logic                     bb_vld
    );
        if (ba_vld && (ba.index == index)) begin
            return ba.set;
        end else if (bb_vld && (bb.index == index)) begin
            return bb.set;
        end
        return ram_set;
    endfunction

    // ============================================================
    // request accept and line b
    // ============================================================
    assign req_rdy  = !busy && !stall;
    assign req_fire = req_vld && req_rdy;

    // fetch window runs past the end of the line
    assign crossing  = req.addr.offset > ((1 << `ICT_OFFSET_W) - `ICT_FETCH_BYTES);
    assign addr_next = req.addr + {{(`ICT_ADDR_W-`ICT_OFFSET_W-1){1'b0}}, 1'b1,
                                   {`ICT_OFFSET_W{1'b0}}};

    always_comb begin
        req_line_b      = req;
        req_line_b.addr = crossing ? addr_next : req.addr;
    end

    assign req_index_a = req.addr.index;
    assign req_index_b = req_line_b.addr.index;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            vld <= 1'b0;
        end else begin
            vld <= req_fire;
        end
    end

    always_ff @(posedge clk) begin
        if (req_fire) begin
            req_a_q <= req;
            req_b_q <= req_line_b;
        end
    end

    // ============================================================
    // hit check
    // ============================================================
    assign set_a = resolve(req_a_q.addr.index, rd_a, buf_a, buf_a_vld, buf_b, buf_b_vld);
    assign set_b = resolve(req_b_q.addr.index, rd_b, buf_a, buf_a_vld, buf_b, buf_b_vld);

    assign hit_a  = vld ? icache_tag_pkg::way_hit(set_a, req_a_q.addr.tag) : '0;
    assign hit_b  = vld ? icache_tag_pkg::way_hit(set_b, req_b_q.addr.tag) : '0;
    assign miss_a = vld && (hit_a == '0);
    assign miss_b = vld && (hit_b == '0);

    assign lookup_a = '{valid: vld, req: req_a_q, set: set_a};
    assign lookup_b = '{valid: vld, req: req_b_q, set: set_b};

    // ============================================================
    // bypass read and miss entry
    // ============================================================
    // hit_x[0] is the way 1 hit, so it is also the way number
    assign dest_a = (|hit_a) ? hit_a[0] : victim_a;
    assign dest_b = (|hit_b) ? hit_b[0] : victim_b;

    assign bypass_vld = (|hit_a) && (|hit_b) && dataram_rd_rdy;
    assign bypass_a   = '{index: req_a_q.addr.index, way: hit_a[0], txnid: req_a_q.txnid};
    assign bypass_b   = '{index: req_b_q.addr.index, way: hit_b[0], txnid: req_b_q.txnid};

    assign entry_vld = vld && (req_a_q.opcode != icache_tag_pkg::op_downstream);
    assign entry     = '{req_a: req_a_q, req_b: req_b_q, dest_way_a: dest_a, dest_way_b: dest_b};

endmodule

/* hdl/tag_refill_buffer.sv */
`timescale 1ns/1ps
`include "icache_tag_defs.svh"

module tag_refill_buffer (
    input  logic                      clk,
    input  logic                      rst_n,
    input  icache_tag_pkg::lookup_t   lookup_a,
    input  icache_tag_pkg::lookup_t   lookup_b,
    input  logic                      victim_a,
    input  logic                      victim_b,
    input  logic [`ICT_INDEX_W-1:0]   req_index_a,
    input  logic [`ICT_INDEX_W-1:0]   req_index_b,
    input  logic                      req_fire,
    output icache_tag_pkg::refill_t   buf_a,
    output icache_tag_pkg::refill_t   buf_b,
    output logic                      buf_a_vld,
    output logic                      buf_b_vld,
    output logic                      busy,
    output logic                      ram_en,
    output logic                      ram_wr,
    output logic [`ICT_INDEX_W-1:0]   ram_addr_a,
    output logic [`ICT_INDEX_W-1:0]   ram_addr_b,
    output icache_tag_pkg::tag_set_t  ram_wdata
);

    logic load_a;
    logic load_b;

    // resolved set with the victim way replaced by the new tag
    function automatic icache_tag_pkg::refill_t fill_set(icache_tag_pkg::lookup_t lk, logic victim);
        icache_tag_pkg::tag_way_t nw;
        icache_tag_pkg::refill_t  r;
        nw      = '{valid: 1'b1, tag: lk.req.addr.tag};
        r.index = lk.req.addr.index;
        r.set   = lk.set;
        if (victim) begin
            r.set.way1 = nw;
        end else begin
            r.set.way0 = nw;
        end
        return r;
    endfunction

    // ============================================================
    // buffer load
    // ============================================================
    assign load_a = lookup_a.valid && (icache_tag_pkg::way_hit(lookup_a.set, lookup_a.req.addr.tag) == '0);
    // same set as a means a already covers it
    assign load_b = lookup_b.valid && (icache_tag_pkg::way_hit(lookup_b.set, lookup_b.req.addr.tag) == '0)
                    && (lookup_b.req.addr.index != lookup_a.req.addr.index);

    always_ff @(posedge clk) begin
        if (load_a) begin
            buf_a <= fill_set(lookup_a, victim_a);
        end
        if (load_b) begin
            buf_b <= fill_set(lookup_b, victim_b);
        end
    end

    // a writes first, b waits one cycle behind it
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            buf_a_vld <= 1'b0;
            buf_b_vld <= 1'b0;
        end else begin
            buf_a_vld <= load_a;
            if (load_b) begin
                buf_b_vld <= 1'b1;
            end else if (!buf_a_vld) begin
                buf_b_vld <= 1'b0;
            end
        end
    end

    // a double refill also holds off the request that would follow it
    assign busy = buf_a_vld || buf_b_vld || (load_a && load_b);

    // ============================================================
    // ram port mux, refill writes before new reads
    // ============================================================
    assign ram_wr    = buf_a_vld || buf_b_vld;
    assign ram_en    = ram_wr || req_fire;
    assign ram_wdata = buf_a_vld ? buf_a.set : buf_b.set;

    always_comb begin
        if (buf_a_vld) begin
            ram_addr_a = buf_a.index;
            ram_addr_b = buf_a.index;
        end else if (buf_b_vld) begin
            ram_addr_a = buf_b.index;
            ram_addr_b = buf_b.index;
        end else begin
            ram_addr_a = req_index_a;
            ram_addr_b = req_index_b;
        end
    end

endmodule

/* hdl/tag_sram.sv */
`timescale 1ns/1ps
`include "icache_tag_defs.svh"

module tag_sram (
    input  logic                      clk,
    input  logic                      en,
    input  logic                      wr_en,
    input  logic [`ICT_INDEX_W-1:0]   addr,
    input  icache_tag_pkg::tag_set_t  wr_data,
    output icache_tag_pkg::tag_set_t  rd_data
);

    icache_tag_pkg::tag_set_t mem [0:(1 << `ICT_INDEX_W)-1];

    // all ways start out invalid
    initial begin
        for (int i = 0; i < (1 << `ICT_INDEX_W); i++) begin
            mem[i] = '0;
        end
    end

    always_ff @(posedge clk) begin
        if (en && wr_en) begin
            mem[addr] <= wr_data;
        end else if (en) begin
            rd_data <= mem[addr];
        end
    end

endmodule

/* sources.f */
+incdir+hdl
hdl/icache_tag_pkg.sv
hdl/tag_sram.sv
hdl/lru_table.sv
hdl/tag_refill_buffer.sv
hdl/tag_lookup.sv
hdl/icache_tag_ctrl.sv
tb/tag_checker.sv
tb/tb_icache_tag.sv

/* tb/tag_checker.sv */
`timescale 1ns/1ps
`include "icache_tag_defs.svh"

module tag_checker (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         check_vld,
    input  int                           line_no,
    input  logic [`ICT_WAYS-1:0]         exp_hit_a,
    input  logic [`ICT_WAYS-1:0]         exp_hit_b,
    input  logic                         exp_bypass,
    input  logic                         exp_entry,
    input  icache_tag_pkg::miss_entry_t  exp_ent,
    input  logic [`ICT_WAYS-1:0]         hit_a,
    input  logic [`ICT_WAYS-1:0]         hit_b,
    input  logic                         miss_a,
    input  logic                         miss_b,
    input  logic                         bypass_vld,
    input  icache_tag_pkg::dataram_rd_t  bypass_a,
    input  icache_tag_pkg::dataram_rd_t  bypass_b,
    input  logic                         entry_vld,
    input  icache_tag_pkg::miss_entry_t  entry
);

    int pass_count;
    int fail_count;
    int stray_count;
    int line_bad;

    initial begin
        pass_count  = 0;
        fail_count  = 0;
        stray_count = 0;
        line_bad    = 0;
    end

    task automatic mismatch(string what, logic [31:0] got, logic [31:0] want);
        $display("** Error at time %0t: line %0d: %s is %0h, expected %0h",
                 $time, line_no, what, got, want);
        line_bad = 1;
    endtask

    // ============================================================
    // per request compare, one cycle after acceptance
    // ============================================================
    task automatic compare_outputs();
        icache_tag_pkg::dataram_rd_t want_a;
        icache_tag_pkg::dataram_rd_t want_b;
        line_bad = 0;
        // bypass way is the hit way, way 1 sits in bit 0
        want_a.index = exp_ent.req_a.addr.index;
        want_a.way   = exp_hit_a[0];
        want_a.txnid = exp_ent.req_a.txnid;
        want_b.index = exp_ent.req_b.addr.index;
        want_b.way   = exp_hit_b[0];
        want_b.txnid = exp_ent.req_b.txnid;
        if (hit_a !== exp_hit_a) mismatch("hit_a", hit_a, exp_hit_a);
        if (hit_b !== exp_hit_b) mismatch("hit_b", hit_b, exp_hit_b);
        if (miss_a !== (exp_hit_a == '0)) mismatch("miss_a", miss_a, exp_hit_a == '0);
        if (miss_b !== (exp_hit_b == '0)) mismatch("miss_b", miss_b, exp_hit_b == '0);
        if (bypass_vld !== exp_bypass) mismatch("bypass_vld", bypass_vld, exp_bypass);
        if (entry_vld !== exp_entry) mismatch("entry_vld", entry_vld, exp_entry);
        if (exp_entry) begin
            if (entry.req_a !== exp_ent.req_a) mismatch("entry req_a", entry.req_a, exp_ent.req_a);
            if (entry.req_b !== exp_ent.req_b) mismatch("entry req_b", entry.req_b, exp_ent.req_b);
            if (entry.dest_way_a !== exp_ent.dest_way_a)
                mismatch("dest_way_a", entry.dest_way_a, exp_ent.dest_way_a);
            if (entry.dest_way_b !== exp_ent.dest_way_b)
                mismatch("dest_way_b", entry.dest_way_b, exp_ent.dest_way_b);
        end
        if (exp_bypass) begin
            if (bypass_a !== want_a) mismatch("bypass_a", bypass_a, want_a);
            if (bypass_b !== want_b) mismatch("bypass_b", bypass_b, want_b);
        end
        if (line_bad == 0) begin
            $display("line %0d ok at time %0t", line_no, $time);
            pass_count++;
        end else begin
            fail_count++;
        end
    endtask

    // mid cycle, away from both edges
    always @(negedge clk) begin
        if (check_vld) begin
            compare_outputs();
        end else if (rst_n && (entry_vld || bypass_vld || miss_a || miss_b)) begin
            $display("output strobe high at time %0t with no request in flight", $time);
            stray_count++;
        end
    end

endmodule

/* tb/tag_trace.txt */
# addr op txnid rdy | expected: hit_a hit_b bypass_vld entry_vld dest_way_a dest_way_b
# hex fields except hit_a/hit_b, which are binary with way 0 in the msb
0880 0 1 1 00 00 0 1 0 0
0880 0 2 1 10 10 1 1 0 0
0880 0 3 0 10 10 0 1 0 0
1090 0 4 1 00 00 0 1 1 1
1880 0 5 1 00 00 0 1 1 1
0880 0 6 1 10 10 1 1 0 0
1880 0 7 1 01 01 1 1 1 1
1090 0 8 0 00 00 0 1 0 0
093c 0 9 1 00 00 0 1 0 0
0940 0 a 1 10 10 1 1 0 0
097a 0 b 1 10 00 0 1 0 0
0988 0 c 1 10 10 1 1 0 0
0880 1 d 1 00 00 0 0 1 1
1090 1 e 1 10 10 1 0 0 0
0880 0 f 0 01 01 0 1 1 1
2260 0 0 1 00 00 0 1 0 0
2a40 0 1 1 00 00 0 1 0 0
2260 0 2 1 00 00 0 1 1 1
2a40 0 3 1 10 10 1 1 0 0
0ff9 0 4 1 00 00 0 1 0 0
1000 0 5 1 10 10 1 1 0 0
0ff8 0 6 1 10 10 1 1 0 0

/* tb/tb_icache_tag.sv */
`timescale 1ns/1ps
`include "icache_tag_defs.svh"

module tb_icache_tag;

    logic                        clk;
    logic                        rst_n;
    logic                        req_vld;
    logic                        req_rdy;
    logic                        stall;
    logic                        dataram_rd_rdy;
    icache_tag_pkg::fetch_req_t  req;
    logic [`ICT_WAYS-1:0]        hit_a;
    logic [`ICT_WAYS-1:0]        hit_b;
    logic                        miss_a;
    logic                        miss_b;
    logic                        bypass_vld;
    icache_tag_pkg::dataram_rd_t bypass_a;
    icache_tag_pkg::dataram_rd_t bypass_b;
    logic                        entry_vld;
    icache_tag_pkg::miss_entry_t entry;

    // expectations handed to the checker
    logic                        check_vld;
    int                          check_line;
    logic [`ICT_WAYS-1:0]        exp_hit_a;
    logic [`ICT_WAYS-1:0]        exp_hit_b;
    logic                        exp_bypass;
    logic                        exp_entry;
    icache_tag_pkg::miss_entry_t exp_ent;

    // trace columns
    logic [`ICT_ADDR_W-1:0]  t_addr[$];
    logic                    t_op[$];
    logic [`ICT_TXNID_W-1:0] t_txn[$];
    logic                    t_rdy[$];
    logic [1:0]              t_hit_a[$];
    logic [1:0]              t_hit_b[$];
    logic                    t_byp[$];
    logic                    t_ent[$];
    logic                    t_dwa[$];
    logic                    t_dwb[$];

    int          n_lines;
    int          cycle_count;
    int          cycle_limit;
    logic [31:0] rng;

    icache_tag_ctrl UUT (
        .clk            (clk),
        .rst_n          (rst_n),
        .req_vld        (req_vld),
        .req            (req),
        .req_rdy        (req_rdy),
        .stall          (stall),
        .dataram_rd_rdy (dataram_rd_rdy),
        .hit_a          (hit_a),
        .hit_b          (hit_b),
        .miss_a         (miss_a),
        .miss_b         (miss_b),
        .bypass_vld     (bypass_vld),
        .bypass_a       (bypass_a),
        .bypass_b       (bypass_b),
        .entry_vld      (entry_vld),
        .entry          (entry)
    );

    tag_checker u_check (
        .clk        (clk),
        .rst_n      (rst_n),
        .check_vld  (check_vld),
        .line_no    (check_line),
        .exp_hit_a  (exp_hit_a),
        .exp_hit_b  (exp_hit_b),
        .exp_bypass (exp_bypass),
        .exp_entry  (exp_entry),
        .exp_ent    (exp_ent),
        .hit_a      (hit_a),
        .hit_b      (hit_b),
        .miss_a     (miss_a),
        .miss_b     (miss_b),
        .bypass_vld (bypass_vld),
        .bypass_a   (bypass_a),
        .bypass_b   (bypass_b),
        .entry_vld  (entry_vld),
        .entry      (entry)
    );

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
            $display("timeout: the run did not finish within %0d cycles", cycle_limit);
            $display("sim failed");
            $finish;
        end
    end

    function automatic logic [31:0] xorshift32(logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // window past the line end moves lookup b to the next line
    function automatic logic [`ICT_ADDR_W-1:0] line_b_addr(logic [`ICT_ADDR_W-1:0] a);
        if (a[`ICT_OFFSET_W-1:0] > 56) begin
            return a + (1 << `ICT_OFFSET_W);
        end
        return a;
    endfunction

    task automatic read_trace(output logic ok);
        int          fd;
        int          n;
        string       text;
        logic [31:0] f[10];
        ok = 1'b0;
        fd = $fopen("tb/tag_trace.txt", "r");
        if (fd != 0) begin
            ok = 1'b1;
            while (!$feof(fd)) begin
                text = "";
                void'($fgets(text, fd));
                if (text.len() > 0 && text[0] != "#") begin
                    n = $sscanf(text, "%h %h %h %h %b %b %h %h %h %h", f[0], f[1], f[2], f[3],
                                f[4], f[5], f[6], f[7], f[8], f[9]);
                    if (n == 10) begin
                        t_addr.push_back(f[0][`ICT_ADDR_W-1:0]);
                        t_op.push_back(f[1][0]);
                        t_txn.push_back(f[2][`ICT_TXNID_W-1:0]);
                        t_rdy.push_back(f[3][0]);
                        t_hit_a.push_back(f[4][1:0]);
                        t_hit_b.push_back(f[5][1:0]);
                        t_byp.push_back(f[6][0]);
                        t_ent.push_back(f[7][0]);
                        t_dwa.push_back(f[8][0]);
                        t_dwb.push_back(f[9][0]);
                    end
                end
            end
            $fclose(fd);
        end
        n_lines = t_addr.size();
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #1;
        check_vld = 1'b0;
    endtask

    // ============================================================
    // driver
    // ============================================================
    task automatic send_line(int i);
        int   gap;
        logic accepted;
        rng = xorshift32(rng);
        gap = rng % 4;
        // right after a miss, follow at once so forwarding is used
        if (i > 0 && t_hit_a[i-1] == 2'b00) begin
            gap = 0;
        end
        repeat (gap) next_cycle();
        req.addr   = t_addr[i];
        req.opcode = icache_tag_pkg::opcode_e'(t_op[i]);
        req.txnid  = t_txn[i];
        req_vld    = 1'b1;
        stall      = (gap != 0) && (rng[6:4] == 3'd0);
        accepted   = 1'b0;
        while (!accepted) begin
            @(negedge clk);
            accepted = req_rdy;
            next_cycle();
            stall = 1'b0;
        end
        req_vld            = 1'b0;
        dataram_rd_rdy     = t_rdy[i];
        exp_hit_a          = t_hit_a[i];
        exp_hit_b          = t_hit_b[i];
        exp_bypass         = t_byp[i];
        exp_entry          = t_ent[i];
        exp_ent.req_a      = req;
        exp_ent.req_b      = req;
        exp_ent.req_b.addr = line_b_addr(t_addr[i]);
        exp_ent.dest_way_a = t_dwa[i];
        exp_ent.dest_way_b = t_dwb[i];
        check_line         = i + 1;
        check_vld          = 1'b1;
    endtask

    initial begin
        logic ok;
        clk            = 1'b0;
        rst_n          = 1'b0;
        req_vld        = 1'b0;
        req            = '0;
        stall          = 1'b0;
        dataram_rd_rdy = 1'b0;
        check_vld      = 1'b0;
        check_line     = 0;
        exp_hit_a      = '0;
        exp_hit_b      = '0;
        exp_bypass     = 1'b0;
        exp_entry      = 1'b0;
        exp_ent        = '0;
        cycle_count    = 0;
        cycle_limit    = 0;
        rng            = 32'h31e48b6f;
        read_trace(ok);
        if (!ok || n_lines == 0) begin
            $display("no usable lines read from tb/tag_trace.txt");
            $display("sim failed");
            $finish;
        end else begin
            cycle_limit = n_lines * 8 + 20;
            repeat (5) @(posedge clk);
            #1;
            rst_n = 1'b1;
            for (int i = 0; i < n_lines; i++) begin
                send_line(i);
            end
            next_cycle();
            next_cycle();
            $display("checked %0d of %0d lines, passed %0d, failed %0d, stray strobes %0d",
                     u_check.pass_count + u_check.fail_count, n_lines,
                     u_check.pass_count, u_check.fail_count, u_check.stray_count);
            if (u_check.fail_count == 0 && u_check.stray_count == 0
                && u_check.pass_count == n_lines) begin
                $display("sim passed");
            end else begin
                $display("sim failed");
            end
            $finish;
        end
    end

endmodule
